//--- dv/rv_core_vectors.txt
// sections, then per section: pair count, addr word pairs, hang lo hi,
// kind (1 halt, 2 bus error) and halt pc, expected pair count, addr word pairs
2
2b
0 00c00093  4 ff800113  8 20000513  c 002081b3  10 00352023  14 402081b3
18 00352223  1c 0020f1b3  20 00352423  24 0020e1b3  28 00352623  2c 0020c1b3
30 00352823  34 002091b3  38 00352a23  3c 40215193  40 00352c23  44 01c15193
48 00352e23  4c 001121b3  50 02352023  54 001131b3  58 02352223  5c 10052203
60 abcde2b7  64 12328293  68 00520333  6c 02652423  70 00500013  74 02052623
78 00300393  7c 00000413  80 00140413  84 fff38393  88 fe039ce3  8c 02852823
90 00838463  94 02852a23  98 008004ef  9c 00000493  a0 02952c23  a4 00100073
300 12345678
ffffffff 0
1 a4
f
200 00000004  204 00000014  208 00000008  20c fffffffc  210 fffffff4
214 0c000000  218 fffffffe  21c 0000000f  220 00000001  224 00000000
228 be02379b  22c 00000000  230 00000003  234 00000003  238 0000009c
// second run, load from a hang address
3
0 3f000093  4 0000a103  8 00100073
3f0 3ff
2 4
0

//--- src.f
rtl/rv_pkg.sv
rtl/mem_req_if.sv
rtl/rv_alu.sv
rtl/rv_regfile.sv
rtl/rv_decoder.sv
rtl/rv_ctrl.sv
rtl/apb_master.sv
rtl/bus_timer.sv
rtl/rv_core_top.sv
dv/rv_core_chk.sv
dv/rv_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module rv_core_tb -o rv_core_sim
if [ $? -ne 0 ]; then
  echo "compile step failed"
  exit 1
fi

./obj_dir/rv_core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Test passed$" sim.log; then
  exit 0
fi
exit 1

//--- dv/rv_core_tb.sv
`timescale 1ns/100ps

module rv_core_tb;

  logic        clk;
  logic        rst;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic [31:0] paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [3:0]  pstrb;
  logic        halted;
  logic        bus_error;
  logic [31:0] pc;

  logic [31:0] vec [0:255];
  logic [31:0] mem [0:255]; // 1 KB, word indexed
  logic [31:0] lfsr;
  logic [31:0] hang_lo, hang_hi;
  logic [31:0] acc_addr;
  logic        hang_q;
  int          wait_left;
  int          vp;
  int          watch_cycles;
  bit          loaded;

  rv_core_top dut0 (
    .clk       (clk),
    .rst       (rst),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .pstrb     (pstrb),
    .halted    (halted),
    .bus_error (bus_error),
    .pc        (pc)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_wait(output int w);
    lfsr = lfsr_next(lfsr);
    w = int'(lfsr[0]);
    lfsr = lfsr_next(lfsr);
    w = w * 2 + int'(lfsr[0]);
  endtask

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH %s expected %h actual %h", name, expected, actual);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic respond();
    prdata = mem[acc_addr[9:2]];
    pslverr = 1'b0;
    pready = 1'b1;
  endtask

  // APB slave, responses 1 ns after the edge
  always @(posedge clk) begin
    if (rst) begin
      #1;
      pready = 1'b0;
      pslverr = 1'b0;
      wait_left = 0;
      hang_q = 1'b0;
    end else if (psel && penable && pready) begin
      if (pwrite) mem[paddr[9:2]] = pwdata;
      #1;
      pready = 1'b0;
    end else if (psel && !penable) begin
      check_value("pstrb", 32'hf, {28'b0, pstrb}); // word accesses only
      acc_addr = paddr;
      hang_q = (paddr >= hang_lo) && (paddr <= hang_hi);
      draw_wait(wait_left);
      #1;
      if (!hang_q && wait_left == 0) respond();
    end else if (psel && penable && !hang_q) begin
      if (wait_left > 0) wait_left--;
      #1;
      if (wait_left == 0) respond();
    end
  end

  // sum of program words over all sections
  function automatic int count_words();
    int p;
    int total;
    p = 1;
    total = 0;
    for (int s = 0; s < vec[0]; s++) begin
      total += vec[p];
      p += 1 + 2 * vec[p] + 4;
      p += 1 + 2 * vec[p];
    end
    return total;
  endfunction

  task automatic load_section(output logic [31:0] kind, output logic [31:0] halt_pc);
    int n;
    logic [31:0] a;
    for (int i = 0; i < 256; i++) begin
      a = i * 4;
      mem[i] = 32'hc0de_0000 ^ (a * 32'h0001_0003) ^ {a[9:2], 24'h0};
    end
    n = vec[vp];
    vp++;
    for (int i = 0; i < n; i++) begin
      a = vec[vp];
      mem[a[9:2]] = vec[vp + 1];
      vp += 2;
    end
    hang_lo = vec[vp];
    hang_hi = vec[vp + 1];
    kind = vec[vp + 2];
    halt_pc = vec[vp + 3];
    vp += 4;
  endtask

  task automatic run_section(input int sec);
    logic [31:0] kind;
    logic [31:0] halt_pc;
    logic [31:0] a;
    int n;
    @(posedge clk);
    #1;
    rst = 1'b1;
    load_section(kind, halt_pc);
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    check_value("pc after reset", 32'h0, pc);
    check_value("halted after reset", 32'h0, {31'b0, halted});
    check_value("bus_error after reset", 32'h0, {31'b0, bus_error});
    do begin
      @(posedge clk);
      #2;
    end while (!halted && !bus_error);
    if (kind == 32'd1) begin
      check_value($sformatf("section %0d halted", sec), 32'h1, {31'b0, halted});
      check_value($sformatf("section %0d bus_error", sec), 32'h0, {31'b0, bus_error});
    end else begin
      check_value($sformatf("section %0d bus_error", sec), 32'h1, {31'b0, bus_error});
      check_value($sformatf("section %0d halted", sec), 32'h0, {31'b0, halted});
    end
    check_value($sformatf("section %0d halt pc", sec), halt_pc, pc);
    repeat (5) begin // core must stay off the bus
      @(posedge clk);
      #2;
      check_value("psel after stop", 32'h0, {31'b0, psel});
      check_value("halt state held", kind, {30'b0, bus_error, halted});
    end
    n = vec[vp];
    vp++;
    for (int i = 0; i < n; i++) begin
      a = vec[vp];
      check_value($sformatf("mem[%h]", a), vec[vp + 1], mem[a[9:2]]);
      vp += 2;
    end
  endtask

  initial begin
    rst = 1'b1;
    prdata = '0;
    pready = 1'b0;
    pslverr = 1'b0;
    hang_lo = 32'hffff_ffff;
    hang_hi = 32'h0;
    hang_q = 1'b0;
    wait_left = 0;
    loaded = 1'b0;
    lfsr = 32'h7bea_c49f;
    $readmemh("dv/rv_core_vectors.txt", vec);
    if ($isunknown(vec[0]) || vec[0] == 0) begin
      report_failure("vector file dv/rv_core_vectors.txt could not be read");
    end
    watch_cycles = count_words() * 40 + 200;
    loaded = 1'b1;
    vp = 1;
    for (int s = 0; s < vec[0]; s++) begin
      run_section(s);
    end
    $display("Test passed");
    $finish;
  end

  initial begin
    wait (loaded);
    repeat (watch_cycles) @(posedge clk);
    report_failure("watchdog expired before the core stopped");
  end

endmodule

//--- dv/rv_core_chk.sv
`timescale 1ns/100ps

module rv_core_chk (
  input logic        clk,
  input logic        rst,
  input logic        psel,
  input logic        penable,
  input logic        pready,
  input logic        pwrite,
  input logic [31:0] paddr,
  input logic [31:0] pwdata,
  input logic        halted,
  input logic        bus_error
);

  // access phase only after one setup cycle
  a_penable_after_setup: assert property (@(posedge clk) disable iff (rst)
    $rose(penable) |-> $past(psel && !penable))
    else $error("penable rose without a preceding setup cycle");

  // a waiting transfer keeps its request fields
  a_request_stable: assert property (@(posedge clk) disable iff (rst)
    (psel && !pready) |=> (!psel || ($stable(paddr) && $stable(pwrite) && $stable(pwdata))))
    else $error("paddr, pwrite or pwdata changed during a transfer");

  a_no_psel_when_stopped: assert property (@(posedge clk) disable iff (rst)
    (halted || bus_error) |-> !psel)
    else $error("psel high after halted or bus_error");

endmodule

bind rv_core_top rv_core_chk u_chk (.*);

//--- rtl/rv_core_top.sv
`timescale 1ns/100ps

module rv_core_top (
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] prdata,
  input  logic        pready,
  input  logic        pslverr,
  output logic [31:0] paddr,
  output logic        psel,
  output logic        penable,
  output logic        pwrite,
  output logic [31:0] pwdata,
  output logic [3:0]  pstrb,
  output logic        halted,
  output logic        bus_error,
  output logic [31:0] pc
);

  logic [31:0]         instr;
  logic [4:0]          rs1, rs2, rd;
  logic [31:0]         imm;
  rv_pkg::alu_op_e     dec_alu_op;
  rv_pkg::alu_op_e     alu_op_sel;
  rv_pkg::inst_class_e cls;
  logic                funct3_0;
  logic [31:0]         rs1_data, rs2_data;
  logic [31:0]         alu_a, alu_b, alu_result;
  logic                alu_eq;
  logic                rd_we;
  logic [31:0]         rd_wdata;
  logic                in_access;
  logic                timeout;

  mem_req_if mem_bus ();

  rv_ctrl u_ctrl (
    .clk        (clk),
    .rst        (rst),
    .mem        (mem_bus.requester),
    .cls        (cls),
    .alu_op     (dec_alu_op),
    .imm        (imm),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .alu_result (alu_result),
    .alu_eq     (alu_eq),
    .funct3_0   (funct3_0),
    .instr      (instr),
    .alu_a      (alu_a),
    .alu_b      (alu_b),
    .alu_op_sel (alu_op_sel),
    .rd_we      (rd_we),
    .rd_wdata   (rd_wdata),
    .halted     (halted),
    .bus_error  (bus_error),
    .pc         (pc)
  );

  rv_decoder u_decoder (
    .instr    (instr),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (rd),
    .imm      (imm),
    .alu_op   (dec_alu_op),
    .cls      (cls),
    .funct3_0 (funct3_0)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (rd),
    .we       (rd_we),
    .wdata    (rd_wdata),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_alu u_alu (
    .op     (alu_op_sel),
    .a      (alu_a),
    .b      (alu_b),
    .result (alu_result),
    .eq     (alu_eq)
  );

  apb_master u_apb (
    .clk       (clk),
    .rst       (rst),
    .mem       (mem_bus.completer),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .timeout   (timeout),
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .pstrb     (pstrb),
    .in_access (in_access)
  );

  bus_timer u_timer (
    .clk       (clk),
    .rst       (rst),
    .in_access (in_access),
    .timeout   (timeout)
  );

endmodule

//--- rtl/bus_timer.sv
`timescale 1ns/100ps

module bus_timer (
  input  logic clk,
  input  logic rst,
  input  logic in_access,
  output logic timeout
);

  logic [rv_pkg::bus_timer_w-1:0] count_q;

  // restarts for every access phase
  always_ff @(posedge clk) begin
    if (rst || !in_access) begin
      count_q <= '0;
    end else begin
      count_q <= count_q + 1'b1;
    end
  end

  assign timeout = (32'(count_q) == rv_pkg::bus_timeout_cycles);

endmodule

//--- rtl/apb_master.sv
`timescale 1ns/100ps

module apb_master (
  input  logic         clk,
  input  logic         rst,
  mem_req_if.completer mem,
  input  logic [31:0]  prdata,
  input  logic         pready,
  input  logic         pslverr,
  input  logic         timeout,
  output logic [31:0]  paddr,
  output logic         psel,
  output logic         penable,
  output logic         pwrite,
  output logic [31:0]  pwdata,
  output logic [3:0]   pstrb,
  output logic         in_access
);

  typedef enum logic [1:0] {ap_idle, ap_setup, ap_access} apb_phase_e;

  apb_phase_e  state_q, phase;
  logic [31:0] addr_q;
  logic [31:0] wdata_q;
  logic        write_q;

  // setup is the idle cycle in which a request shows up
  assign phase = (state_q == ap_idle && mem.req) ? ap_setup : state_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ap_idle;
    end else if (phase == ap_setup) begin
      state_q <= ap_access;
    end else if (mem.done) begin
      state_q <= ap_idle;
    end
  end

  always_ff @(posedge clk) begin
    if (phase == ap_setup) begin
      addr_q  <= mem.addr;
      wdata_q <= mem.wdata;
      write_q <= mem.write;
    end
  end

  assign in_access = (phase == ap_access);
  assign psel      = (phase != ap_idle);
  assign penable   = in_access;
  assign paddr     = in_access ? addr_q : mem.addr;
  assign pwdata    = in_access ? wdata_q : mem.wdata;
  assign pwrite    = in_access ? write_q : mem.write;
  assign pstrb     = 4'hf; // word accesses only

  assign mem.done  = in_access && (pready || timeout);
  assign mem.err   = in_access && (pready ? pslverr : timeout);
  assign mem.rdata = prdata;

endmodule

//--- rtl/rv_ctrl.sv
`timescale 1ns/100ps

module rv_ctrl (
  input  logic                clk,
  input  logic                rst,
  mem_req_if.requester        mem,
  input  rv_pkg::inst_class_e cls,
  input  rv_pkg::alu_op_e     alu_op,
  input  logic [31:0]         imm,
  input  logic [31:0]         rs1_data,
  input  logic [31:0]         rs2_data,
  input  logic [31:0]         alu_result,
  input  logic                alu_eq,
  input  logic                funct3_0,
  output logic [31:0]         instr,
  output logic [31:0]         alu_a,
  output logic [31:0]         alu_b,
  output rv_pkg::alu_op_e     alu_op_sel,
  output logic                rd_we,
  output logic [31:0]         rd_wdata,
  output logic                halted,
  output logic                bus_error,
  output logic [31:0]         pc
);

  rv_pkg::ctrl_state_e state_q, state_d;
  logic [31:0] result_q; // alu result, load data or link address
  logic        taken_q;
  logic [31:0] pc_plus4;
  logic [31:0] pc_target;
  logic        is_mem_op;
  logic        writes_rd;

  assign pc_plus4  = pc + 32'd4;
  assign pc_target = pc + imm;
  assign is_mem_op = (cls == rv_pkg::cls_load) || (cls == rv_pkg::cls_store);
  assign writes_rd = (cls == rv_pkg::cls_alu_reg) || (cls == rv_pkg::cls_alu_imm) ||
                     (cls == rv_pkg::cls_lui) || (cls == rv_pkg::cls_load) ||
                     (cls == rv_pkg::cls_jal);

  always_comb begin
    alu_a      = rs1_data;
    alu_b      = imm;
    alu_op_sel = alu_op;
    case (cls)
      rv_pkg::cls_alu_reg: alu_b = rs2_data;
      rv_pkg::cls_branch: begin
        alu_b      = rs2_data;
        alu_op_sel = rv_pkg::alu_sub;
      end
      rv_pkg::cls_load, rv_pkg::cls_store: alu_op_sel = rv_pkg::alu_add; // address
      default: alu_b = imm;
    endcase
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      rv_pkg::st_fetch:
        if (mem.done) state_d = mem.err ? rv_pkg::st_error : rv_pkg::st_decode;
      rv_pkg::st_decode:
        state_d = (cls == rv_pkg::cls_illegal) ? rv_pkg::st_error : rv_pkg::st_execute;
      rv_pkg::st_execute:
        state_d = is_mem_op ? rv_pkg::st_mem : rv_pkg::st_writeback;
      rv_pkg::st_mem:
        if (mem.done) state_d = mem.err ? rv_pkg::st_error : rv_pkg::st_writeback;
      rv_pkg::st_writeback:
        state_d = (cls == rv_pkg::cls_ebreak) ? rv_pkg::st_halt : rv_pkg::st_fetch;
      default: state_d = state_q; // halt and error hold until reset
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= rv_pkg::st_fetch;
      pc      <= rv_pkg::reset_pc;
      taken_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == rv_pkg::st_execute) begin
        taken_q <= (cls == rv_pkg::cls_jal) ||
                   (cls == rv_pkg::cls_branch && (alu_eq != funct3_0));
      end
      // ebreak leaves pc on itself
      if (state_q == rv_pkg::st_writeback && cls != rv_pkg::cls_ebreak) begin
        pc <= taken_q ? pc_target : pc_plus4;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == rv_pkg::st_fetch && mem.done && !mem.err) instr <= mem.rdata;
    if (state_q == rv_pkg::st_execute) begin
      result_q <= (cls == rv_pkg::cls_jal) ? pc_plus4 : alu_result;
    end else if (state_q == rv_pkg::st_mem && mem.done && cls == rv_pkg::cls_load) begin
      result_q <= mem.rdata;
    end
  end

  assign mem.req   = (state_q == rv_pkg::st_fetch) || (state_q == rv_pkg::st_mem);
  assign mem.write = (state_q == rv_pkg::st_mem) && (cls == rv_pkg::cls_store);
  assign mem.addr  = (state_q == rv_pkg::st_mem) ? result_q : pc;
  assign mem.wdata = rs2_data;

  assign rd_we     = (state_q == rv_pkg::st_writeback) && writes_rd;
  assign rd_wdata  = result_q;
  assign halted    = (state_q == rv_pkg::st_halt);
  assign bus_error = (state_q == rv_pkg::st_error);

endmodule

//--- rtl/rv_decoder.sv
`timescale 1ns/100ps

module rv_decoder (
  input  logic [31:0]         instr,
  output logic [4:0]          rs1,
  output logic [4:0]          rs2,
  output logic [4:0]          rd,
  output logic [31:0]         imm,
  output rv_pkg::alu_op_e     alu_op,
  output rv_pkg::inst_class_e cls,
  output logic                funct3_0
);

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [31:0]     imm_i, imm_s, imm_b, imm_u, imm_j;
  logic            op_legal;
  logic            op_imm_legal;
  rv_pkg::alu_op_e base_op;

  assign opcode   = instr[6:0];
  assign funct3   = instr[14:12];
  assign funct7   = instr[31:25];
  assign rs1      = instr[19:15];
  assign rs2      = instr[24:20];
  assign rd       = instr[11:7];
  assign funct3_0 = instr[12]; // beq vs bne

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // funct7 only matters for sub and the shifts
  assign op_legal = (funct7 == 7'h00) ||
                    (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101));
  assign op_imm_legal = (funct3 == 3'b001) ? (funct7 == 7'h00) :
                        (funct3 == 3'b101) ? (funct7 == 7'h00 || funct7 == 7'h20) : 1'b1;

  always_comb begin
    case (funct3)
      3'b000:  base_op = rv_pkg::alu_add;
      3'b001:  base_op = rv_pkg::alu_sll;
      3'b010:  base_op = rv_pkg::alu_slt;
      3'b011:  base_op = rv_pkg::alu_sltu;
      3'b100:  base_op = rv_pkg::alu_xor;
      3'b101:  base_op = funct7[5] ? rv_pkg::alu_sra : rv_pkg::alu_srl;
      3'b110:  base_op = rv_pkg::alu_or;
      default: base_op = rv_pkg::alu_and;
    endcase
  end

  always_comb begin
    cls    = rv_pkg::cls_illegal;
    alu_op = rv_pkg::alu_add;
    imm    = '0;
    case (opcode)
      rv_pkg::opc_op: begin
        cls    = op_legal ? rv_pkg::cls_alu_reg : rv_pkg::cls_illegal;
        alu_op = (funct3 == 3'b000 && funct7[5]) ? rv_pkg::alu_sub : base_op;
      end
      rv_pkg::opc_op_imm: begin
        cls    = op_imm_legal ? rv_pkg::cls_alu_imm : rv_pkg::cls_illegal;
        alu_op = base_op;
        imm    = imm_i;
      end
      rv_pkg::opc_lui: begin
        cls    = rv_pkg::cls_lui;
        alu_op = rv_pkg::alu_pass_b;
        imm    = imm_u;
      end
      rv_pkg::opc_load: begin
        cls = (funct3 == 3'b010) ? rv_pkg::cls_load : rv_pkg::cls_illegal; // lw only
        imm = imm_i;
      end
      rv_pkg::opc_store: begin
        cls = (funct3 == 3'b010) ? rv_pkg::cls_store : rv_pkg::cls_illegal;
        imm = imm_s;
      end
      rv_pkg::opc_branch: begin
        cls    = (funct3[2:1] == 2'b00) ? rv_pkg::cls_branch : rv_pkg::cls_illegal;
        alu_op = rv_pkg::alu_sub;
        imm    = imm_b;
      end
      rv_pkg::opc_jal: begin
        cls = rv_pkg::cls_jal;
        imm = imm_j;
      end
      rv_pkg::opc_system: begin
        cls = (instr == rv_pkg::instr_ebreak) ? rv_pkg::cls_ebreak : rv_pkg::cls_illegal;
      end
      default: cls = rv_pkg::cls_illegal;
    endcase
  end

endmodule

//--- rtl/rv_regfile.sv
`timescale 1ns/100ps

module rv_regfile (
  input  logic        clk,
  input  logic        rst,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  input  logic [4:0]  rd,
  input  logic        we,
  input  logic [31:0] wdata,
  output logic [31:0] rs1_data,
  output logic [31:0] rs2_data
);

  logic [31:0] regs [rv_pkg::num_regs];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < rv_pkg::num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != 5'd0) begin // x0 is hardwired
      regs[rd] <= wdata;
    end
  end

  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

//--- rtl/rv_alu.sv
`timescale 1ns/100ps

module rv_alu (
  input  rv_pkg::alu_op_e op,
  input  logic [31:0]     a,
  input  logic [31:0]     b,
  output logic [31:0]     result,
  output logic            eq
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = b[4:0];
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  // branch compare reads this, independent of op
  assign eq = (a == b);

  always_comb begin
    case (op)
      rv_pkg::alu_add:    result = a + b;
      rv_pkg::alu_sub:    result = a - b;
      rv_pkg::alu_and:    result = a & b;
      rv_pkg::alu_or:     result = a | b;
      rv_pkg::alu_xor:    result = a ^ b;
      rv_pkg::alu_sll:    result = a << shamt;
      rv_pkg::alu_srl:    result = a >> shamt;
      rv_pkg::alu_sra:    result = $unsigned($signed(a) >>> shamt);
      rv_pkg::alu_slt:    result = {31'b0, lt_signed};
      rv_pkg::alu_sltu:   result = {31'b0, lt_unsigned};
      rv_pkg::alu_pass_b: result = b;
      default:            result = '0;
    endcase
  end

endmodule

//--- rtl/mem_req_if.sv
`timescale 1ns/100ps

interface mem_req_if;

  logic                   req;
  logic                   write;
  logic [rv_pkg::xlen-1:0] addr;
  logic [rv_pkg::xlen-1:0] wdata;
  logic                   done;  // one-cycle pulse per transfer
  logic                   err;
  logic [rv_pkg::xlen-1:0] rdata;

  modport requester (output req, write, addr, wdata,
                     input  done, err, rdata);

  modport completer (input  req, write, addr, wdata,
                     output done, err, rdata);

endinterface

//--- rtl/rv_pkg.sv
package rv_pkg;

  localparam int xlen = 32;
  localparam int num_regs = 32;
  localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

  // access-phase cycles without pready before the transfer fails
  localparam int bus_timeout_cycles = 16;
  localparam int bus_timer_w = $clog2(bus_timeout_cycles + 1);

  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_store  = 7'b0100011;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_system = 7'b1110011;

  localparam logic [31:0] instr_ebreak = 32'h0010_0073;

  typedef enum logic [2:0] {
    st_fetch,
    st_decode,
    st_execute,
    st_mem,
    st_writeback,
    st_halt,
    st_error
  } ctrl_state_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor,
    alu_sll, alu_srl, alu_sra, alu_slt, alu_sltu,
    alu_pass_b // lui
  } alu_op_e;

  typedef enum logic [3:0] {
    cls_alu_reg,
    cls_alu_imm,
    cls_lui,
    cls_load,
    cls_store,
    cls_branch,
    cls_jal,
    cls_ebreak,
    cls_illegal
  } inst_class_e;

endpackage
